// File: packet_sram_top.f
+incdir+hw
hw/packet_pkg.sv
hw/imem_sram.sv
hw/packet_fifo.sv
hw/packet_loader.sv
hw/task_decoder.sv
hw/reservation_station.sv
hw/packet_sram_top.sv
verification/tb_packet_sram.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench; a $fatal gives a failing exit status
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_packet_sram \
    -f packet_sram_top.f \
    -o sim_packet_sram

./obj_dir/sim_packet_sram

// File: verification/tb_packet_sram.sv
`timescale 1ns/100ps
`include "packet_defines.svh"

module tb_packet_sram;

    localparam int NUM_PACKETS = 20;
    localparam int NUM_STREAMS = 2;
    localparam int HOLD_CYCLES = 20;       // task_complete must stay high this long
    // 640 serial cycles, a busy window of up to 127 cycles, PE delays and stream waits
    localparam int CYCLE_LIMIT = 5000;

    logic                 clk;
    logic                 rst;
    logic                 packet_bank_data;
    logic                 sos;
    logic                 eos;
    logic [`NUM_PE-1:0]   pe_idle;
    logic [`NUM_PE-1:0]   bank_busy;
    logic [`NUM_PE-1:0]   fv_eos;
    packet_pkg::pe_task_t out_packet_0;
    packet_pkg::pe_task_t out_packet_1;
    packet_pkg::pe_task_t out_packet_2;
    packet_pkg::pe_task_t out_packet_3;
    logic [`NUM_PE-1:0]   out_valid;
    logic                 stream_begin;
    logic                 task_complete;

    logic [31:0]             lfsr_state;
    packet_pkg::cmd_packet_t program_mem [NUM_PACKETS];
    packet_pkg::pe_task_t    exp_payload [$];
    int                      exp_streams [$];   // STREAMs ahead of each task in the program

    packet_sram_top u_packet_sram_top (
        .clk              (clk),
        .rst              (rst),
        .packet_bank_data (packet_bank_data),
        .sos              (sos),
        .eos              (eos),
        .pe_idle          (pe_idle),
        .bank_busy        (bank_busy),
        .fv_eos           (fv_eos),
        .out_packet_0     (out_packet_0),
        .out_packet_1     (out_packet_1),
        .out_packet_2     (out_packet_2),
        .out_packet_3     (out_packet_3),
        .out_valid        (out_valid),
        .stream_begin     (stream_begin),
        .task_complete    (task_complete)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int first_free_pe(input logic [`NUM_PE-1:0] free);
        for (int i = 0; i < `NUM_PE; i++) begin
            if (free[i]) begin
                return i;
            end
        end
        return `NUM_PE;     // No PE could take a task
    endfunction

    function automatic packet_pkg::pe_task_t packet_of(input int pe);
        case (pe)
            0:       return out_packet_0;
            1:       return out_packet_1;
            2:       return out_packet_2;
            default: return out_packet_3;
        endcase
    endfunction

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_task(input string name, input packet_pkg::pe_task_t expected,
                              input packet_pkg::pe_task_t actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_pe(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("mismatch at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %b got %b", $time, name, expected, actual);
            stop_run();
        end
    endtask

    // Two STREAMs at random slots, TASKs elsewhere, END last
    task automatic build_program();
        int pos_a;
        int pos_b;
        int streams;
        pos_a   = int'(rand_bits(5)) % (NUM_PACKETS - 1);
        pos_b   = (pos_a + 1 + int'(rand_bits(4))) % (NUM_PACKETS - 1);
        streams = 0;
        for (int p = 0; p < NUM_PACKETS - 1; p++) begin
            program_mem[p].payload = packet_pkg::pe_task_t'(rand_bits(30));
            if (p == pos_a || p == pos_b) begin
                program_mem[p].opcode = packet_pkg::OP_STREAM;
                streams++;
            end else begin
                program_mem[p].opcode = packet_pkg::OP_TASK;
                exp_payload.push_back(program_mem[p].payload);
                exp_streams.push_back(streams);
            end
        end
        program_mem[NUM_PACKETS-1].opcode  = packet_pkg::OP_END;
        program_mem[NUM_PACKETS-1].payload = '0;
    endtask

    task automatic drive_program();
        for (int p = 0; p < NUM_PACKETS; p++) begin
            for (int b = `PACKET_W - 1; b >= 0; b--) begin
                @(negedge clk);
                packet_bank_data = program_mem[p][b];   // MSB first
                sos              = (p == 0 && b == `PACKET_W - 1);
                eos              = (p == NUM_PACKETS - 1 && b == 0);
            end
        end
        @(negedge clk);
        packet_bank_data = 1'b0;
        sos              = 1'b0;
        eos              = 1'b0;
    endtask

    // Checks outputs and plays the PEs at each falling edge
    task automatic run_monitor();
        int                 cycle_cnt;
        int                 stream_cnt;
        int                 streams_done;
        int                 hold_cnt;
        int                 win_start;
        int                 win_end;
        int                 exp_pe;
        int                 got_pe;
        int                 idle_cnt [`NUM_PE];
        int                 eos_delay [`NUM_PE];
        logic               stream_active;
        logic               sb_prev;
        logic [`NUM_PE-1:0] vld;
        logic [`NUM_PE-1:0] idle_now;
        logic [`NUM_PE-1:0] busy_now;
        cycle_cnt     = 0;
        stream_cnt    = 0;
        streams_done  = 0;
        hold_cnt      = 0;
        win_start     = -1;     // Opened by the first dispatch
        win_end       = 0;
        stream_active = 1'b0;
        sb_prev       = 1'b0;
        for (int i = 0; i < `NUM_PE; i++) begin
            idle_cnt[i]  = 0;
            eos_delay[i] = 0;
        end
        while (hold_cnt < HOLD_CYCLES) begin
            @(negedge clk);
            vld      = out_valid;
            idle_now = pe_idle;     // Values the DUT saw at the last rising edge
            busy_now = bank_busy;
            cycle_cnt++;
            if (cycle_cnt > CYCLE_LIMIT) begin
                $display("timeout: task_complete not held after %0d cycles", CYCLE_LIMIT);
                stop_run();
            end

            if (stream_active && fv_eos == '1) begin
                streams_done++;
                stream_active = 1'b0;
                fv_eos        = '0;
            end else if (stream_active) begin
                for (int i = 0; i < `NUM_PE; i++) begin
                    if (!fv_eos[i] && eos_delay[i] <= 1) begin
                        fv_eos[i] = 1'b1;
                    end else if (!fv_eos[i]) begin
                        eos_delay[i]--;
                    end
                end
            end
            if (stream_begin) begin
                check_flag("stream_begin", stream_cnt < NUM_STREAMS && !sb_prev, 1'b1);
                stream_cnt++;
                stream_active = 1'b1;
                for (int i = 0; i < `NUM_PE; i++) begin
                    eos_delay[i] = 1 + int'(rand_bits(4));
                end
            end
            sb_prev = stream_begin;

            if (vld != '0) begin
                check_flag("out_valid one-hot", 1'b1, $onehot(vld));
                check_flag("dispatch while bank_busy all ones", 1'b0, &busy_now);
                exp_pe = first_free_pe(idle_now & ~busy_now);
                got_pe = first_free_pe(vld);
                check_pe("dispatch PE", exp_pe, got_pe);
                if (exp_payload.size() == 0) begin
                    $display("error at %0t: task sent to PE %0d with none expected", $time, got_pe);
                    stop_run();
                end
                check_flag("fv_eos wait before task", 1'b1, streams_done >= exp_streams[0]);
                check_task($sformatf("out_packet_%0d", got_pe), exp_payload.pop_front(),
                           packet_of(got_pe));
                void'(exp_streams.pop_front());
                idle_cnt[got_pe] = 1 + int'(rand_bits(3));
                if (win_start < 0) begin
                    win_start = cycle_cnt + int'(rand_bits(3));
                    win_end   = win_start + 64 + int'(rand_bits(6));
                end
            end

            for (int i = 0; i < `NUM_PE; i++) begin
                if (vld[i]) begin
                    pe_idle[i] = 1'b0;
                end else if (idle_cnt[i] > 0) begin
                    idle_cnt[i]--;
                    if (idle_cnt[i] == 0) begin
                        pe_idle[i] = 1'b1;
                    end
                end
            end

            if (win_start >= 0 && cycle_cnt >= win_start && cycle_cnt < win_end) begin
                bank_busy = '1;     // Stalls the whole chain back to readback
            end else begin
                for (int i = 0; i < `NUM_PE; i++) begin
                    if (rand_bits(2) == 32'd3) begin
                        bank_busy[i] = ~bank_busy[i];
                    end
                end
            end

            if (task_complete) begin
                if (hold_cnt == 0) begin
                    check_flag("model queue empty at task_complete", 1'b1,
                               exp_payload.size() == 0);
                    check_flag("pe_idle all ones at task_complete", 1'b1, idle_now == '1);
                    check_flag("stream_begin count of two", 1'b1, stream_cnt == NUM_STREAMS);
                end
                hold_cnt++;
            end else begin
                check_flag("task_complete", hold_cnt > 0, 1'b0);
            end
        end
    endtask

    initial begin
        lfsr_state       = 32'ha158;
        rst              = 1'b1;
        packet_bank_data = 1'b0;
        sos              = 1'b0;
        eos              = 1'b0;
        pe_idle          = '1;
        bank_busy        = '0;
        fv_eos           = '0;
        build_program();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        fork
            drive_program();
            run_monitor();
        join
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: hw/packet_sram_top.sv
`timescale 1ns/100ps
`include "packet_defines.svh"

module packet_sram_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 packet_bank_data,
    input  logic                 sos,
    input  logic                 eos,
    input  logic [`NUM_PE-1:0]   pe_idle,
    input  logic [`NUM_PE-1:0]   bank_busy,
    input  logic [`NUM_PE-1:0]   fv_eos,
    output packet_pkg::pe_task_t out_packet_0,
    output packet_pkg::pe_task_t out_packet_1,
    output packet_pkg::pe_task_t out_packet_2,
    output packet_pkg::pe_task_t out_packet_3,
    output logic [`NUM_PE-1:0]   out_valid,
    output logic                 stream_begin,
    output logic                 task_complete
);

    logic                    sram_wen;
    packet_pkg::imem_addr_t  sram_addr;
    logic [`PACKET_W-1:0]    sram_wdata;
    logic [`PACKET_W-1:0]    sram_rdata;
    logic                    cmd_push;
    packet_pkg::cmd_packet_t cmd_push_data;
    logic                    cmd_full;
    logic                    cmd_pop;
    packet_pkg::cmd_packet_t cmd_head;
    logic                    cmd_empty;
    logic                    task_valid;
    packet_pkg::pe_task_t    task_data;
    logic                    rs_full;
    logic                    rs_empty;

    imem_sram u_imem_sram (
        .clk   (clk),
        .wen   (sram_wen),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    packet_loader u_packet_loader (
        .clk              (clk),
        .rst              (rst),
        .packet_bank_data (packet_bank_data),
        .sos              (sos),
        .eos              (eos),
        .sram_wen         (sram_wen),
        .sram_addr        (sram_addr),
        .sram_wdata       (sram_wdata),
        .sram_rdata       (sram_rdata),
        .full             (cmd_full),
        .push             (cmd_push),
        .push_data        (cmd_push_data)
    );

    // Command queue between readback and decode
    packet_fifo #(
        .T     (packet_pkg::cmd_packet_t),
        .DEPTH (`CMD_FIFO_DEPTH)
    ) u_cmd_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (cmd_push),
        .push_data (cmd_push_data),
        .pop       (cmd_pop),
        .rd_data   (cmd_head),
        .full      (cmd_full),
        .empty     (cmd_empty)
    );

    task_decoder u_task_decoder (
        .clk           (clk),
        .rst           (rst),
        .cmd           (cmd_head),
        .cmd_empty     (cmd_empty),
        .cmd_pop       (cmd_pop),
        .task_valid    (task_valid),
        .task_data     (task_data),
        .rs_full       (rs_full),
        .rs_empty      (rs_empty),
        .pe_idle       (pe_idle),
        .fv_eos        (fv_eos),
        .stream_begin  (stream_begin),
        .task_complete (task_complete)
    );

    reservation_station u_reservation_station (
        .clk          (clk),
        .rst          (rst),
        .task_valid   (task_valid),
        .task_data    (task_data),
        .rs_full      (rs_full),
        .rs_empty     (rs_empty),
        .pe_idle      (pe_idle),
        .bank_busy    (bank_busy),
        .out_valid    (out_valid),
        .out_packet_0 (out_packet_0),
        .out_packet_1 (out_packet_1),
        .out_packet_2 (out_packet_2),
        .out_packet_3 (out_packet_3)
    );

endmodule

// File: hw/reservation_station.sv
`timescale 1ns/100ps
`include "packet_defines.svh"

module reservation_station (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 task_valid,
    input  packet_pkg::pe_task_t task_data,
    output logic                 rs_full,
    output logic                 rs_empty,
    input  logic [`NUM_PE-1:0]   pe_idle,
    input  logic [`NUM_PE-1:0]   bank_busy,
    output logic [`NUM_PE-1:0]   out_valid,
    output packet_pkg::pe_task_t out_packet_0,
    output packet_pkg::pe_task_t out_packet_1,
    output packet_pkg::pe_task_t out_packet_2,
    output packet_pkg::pe_task_t out_packet_3
);

    packet_pkg::pe_task_t head;
    packet_pkg::pe_task_t out_pkt [`NUM_PE];
    logic                 fifo_empty;
    logic                 rs_pop;
    logic [`NUM_PE-1:0]   eligible;
    logic [`NUM_PE-1:0]   grant;

    packet_fifo #(
        .T     (packet_pkg::pe_task_t),
        .DEPTH (`RS_DEPTH)
    ) u_rs_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (task_valid),
        .push_data (task_data),
        .pop       (rs_pop),
        .rd_data   (head),
        .full      (rs_full),
        .empty     (fifo_empty)
    );

    // A PE being handed a task this cycle has not yet dropped its idle flag
    assign eligible = pe_idle & ~bank_busy & ~out_valid;
    assign rs_pop   = !fifo_empty && (eligible != '0);
    assign grant    = rs_pop ? (eligible & (~eligible + 1'b1)) : '0;   // Lowest index wins

    assign rs_empty = fifo_empty && (out_valid == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= '0;
        end else begin
            out_valid <= grant;     // One-cycle pulse per dispatch
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_PE; i++) begin
            if (grant[i]) begin
                out_pkt[i] <= head;
            end
        end
    end

    assign out_packet_0 = out_pkt[0];
    assign out_packet_1 = out_pkt[1];
    assign out_packet_2 = out_pkt[2];
    assign out_packet_3 = out_pkt[3];

    a_valid_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(out_valid))
        else $error("more than one PE dispatched");

endmodule

// File: hw/task_decoder.sv
`timescale 1ns/100ps
`include "packet_defines.svh"

module task_decoder (
    input  logic                    clk,
    input  logic                    rst,
    input  packet_pkg::cmd_packet_t cmd,
    input  logic                    cmd_empty,
    output logic                    cmd_pop,
    output logic                    task_valid,
    output packet_pkg::pe_task_t    task_data,
    input  logic                    rs_full,
    input  logic                    rs_empty,
    input  logic [`NUM_PE-1:0]      pe_idle,
    input  logic [`NUM_PE-1:0]      fv_eos,
    output logic                    stream_begin,
    output logic                    task_complete
);

    typedef enum logic [1:0] {
        S_FETCH,
        S_WAIT_STREAM,
        S_WAIT_DRAIN,
        S_DONE
    } state_e;

    state_e              state;
    packet_pkg::opcode_e op;

    assign op        = cmd.opcode;
    assign task_data = cmd.payload;

    // Head of the command FIFO is consumed in the same cycle it is decoded
    always_comb begin
        cmd_pop    = 1'b0;
        task_valid = 1'b0;
        if (state == S_FETCH && !cmd_empty) begin
            if (op == packet_pkg::OP_TASK) begin
                cmd_pop    = !rs_full;
                task_valid = !rs_full;
            end else begin
                cmd_pop = 1'b1;     // STREAM, END and the reserved code
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= S_FETCH;
            stream_begin  <= 1'b0;
            task_complete <= 1'b0;
        end else begin
            stream_begin <= 1'b0;
            case (state)
                S_FETCH: begin
                    if (cmd_pop && op == packet_pkg::OP_STREAM) begin
                        stream_begin <= 1'b1;
                        state        <= S_WAIT_STREAM;
                    end else if (cmd_pop && op == packet_pkg::OP_END) begin
                        state <= S_WAIT_DRAIN;
                    end
                end
                S_WAIT_STREAM: begin
                    // eos lines only count once the pulse has gone out
                    if (!stream_begin && (&fv_eos)) begin
                        state <= S_FETCH;
                    end
                end
                S_WAIT_DRAIN: begin
                    if (rs_empty && (&pe_idle)) begin
                        task_complete <= 1'b1;
                        state         <= S_DONE;
                    end
                end
                default: task_complete <= 1'b1;  // Sticky until reset
            endcase
        end
    end

endmodule

// File: hw/packet_loader.sv
`timescale 1ns/100ps
`include "packet_defines.svh"

module packet_loader (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    packet_bank_data,
    input  logic                    sos,
    input  logic                    eos,
    output logic                    sram_wen,
    output packet_pkg::imem_addr_t  sram_addr,
    output logic [`PACKET_W-1:0]    sram_wdata,
    input  logic [`PACKET_W-1:0]    sram_rdata,
    input  logic                    full,
    output logic                    push,
    output packet_pkg::cmd_packet_t push_data
);

    localparam int AW = $bits(packet_pkg::imem_addr_t);

    typedef enum logic [1:0] {S_IDLE, S_LOAD, S_READ, S_DONE} state_e;

    state_e                       state;
    logic [`PACKET_W-2:0]         shift;
    logic [$clog2(`PACKET_W)-1:0] bit_cnt;
    logic                         last_word;    // eos taken, final write still pending
    logic [AW:0]                  wr_cnt;       // Words written, program length after eos
    logic [AW:0]                  rd_addr;
    logic                         rd_pending;
    logic                         hold_valid;
    packet_pkg::cmd_packet_t      hold;
    logic                         take_bit;
    logic                         word_done;
    logic                         rd_issue;

    assign take_bit  = (state == S_IDLE && sos) || (state == S_LOAD && !last_word);
    assign word_done = take_bit && (bit_cnt == '1);

    // Next read waits for the holding register and any read in flight
    assign rd_issue = (state == S_READ) && !hold_valid && !rd_pending && (rd_addr != wr_cnt);

    assign sram_addr = (state == S_READ) ? rd_addr[AW-1:0] : wr_cnt[AW-1:0];
    assign push      = hold_valid && !full;
    assign push_data = hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            bit_cnt    <= '0;
            last_word  <= 1'b0;
            wr_cnt     <= '0;
            rd_addr    <= '0;
            rd_pending <= 1'b0;
            hold_valid <= 1'b0;
            sram_wen   <= 1'b0;
        end else begin
            sram_wen   <= word_done;
            rd_pending <= rd_issue;
            if (take_bit) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (take_bit && eos) begin
                last_word <= 1'b1;
            end
            if (sram_wen) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (rd_issue) begin
                rd_addr <= rd_addr + 1'b1;
            end
            if (rd_pending) begin
                hold_valid <= 1'b1;
            end else if (push) begin
                hold_valid <= 1'b0;
            end

            case (state)
                S_IDLE: if (sos) state <= S_LOAD;
                S_LOAD: if (sram_wen && last_word) state <= S_READ;
                S_READ: begin
                    if (rd_addr == wr_cnt && !rd_pending && !hold_valid) begin
                        state <= S_DONE;
                    end
                end
                default: state <= S_DONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_bit) begin
            shift <= {shift[`PACKET_W-3:0], packet_bank_data};   // MSB first
        end
        if (word_done) begin
            sram_wdata <= {shift, packet_bank_data};
        end
        if (rd_pending) begin
            hold <= packet_pkg::cmd_packet_t'(sram_rdata);
        end
    end

    // Program memory is frozen once readback starts
    a_no_write_in_readback: assert property (
        @(posedge clk) disable iff (rst) (state inside {S_READ, S_DONE}) |-> !sram_wen
    ) else $error("sram write during readback");

endmodule

// File: hw/packet_fifo.sv
`timescale 1ns/100ps

module packet_fifo #(
    parameter type T     = packet_pkg::cmd_packet_t,
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     rd_data,
    output logic full,
    output logic empty
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T              mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full    = (count == (PW+1)'(DEPTH));
    assign empty   = (count == '0);
    assign rd_data = mem[rd_ptr];   // Head is always visible

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) full |-> !push)
        else $error("push while full");
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) empty |-> !pop)
        else $error("pop while empty");

endmodule

// File: hw/imem_sram.sv
`timescale 1ns/100ps
`include "packet_defines.svh"

// Behavioural model of the compiled instruction memory
module imem_sram (
    input  logic                           clk,
    input  logic                           wen,
    input  logic [$clog2(`IMEM_DEPTH)-1:0] addr,
    input  logic [`PACKET_W-1:0]           wdata,
    output logic [`PACKET_W-1:0]           rdata
);

    logic [`PACKET_W-1:0] mem [`IMEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];     // Read-first, one cycle latency
    end

endmodule

// File: hw/packet_pkg.sv
`include "packet_defines.svh"

package packet_pkg;

    // Opcode lives in the top two bits of a program packet
    typedef enum logic [1:0] {
        OP_TASK   = 2'd0,
        OP_STREAM = 2'd1,
        OP_RSVD   = 2'd2,   // Decoded as a no-op
        OP_END    = 2'd3
    } opcode_e;

    // Payload handed to an edge PE
    typedef logic [`PACKET_W-3:0] pe_task_t;

    typedef struct packed {
        opcode_e  opcode;
        pe_task_t payload;
    } cmd_packet_t;

    typedef logic [$clog2(`IMEM_DEPTH)-1:0] imem_addr_t;

endpackage

// File: hw/packet_defines.svh
`ifndef PACKET_DEFINES_SVH
`define PACKET_DEFINES_SVH

// Program packet and array sizing
`define PACKET_W 32
`define NUM_PE 4

`define IMEM_DEPTH 64     // Instruction SRAM words

// Queue depths
`define CMD_FIFO_DEPTH 4
`define RS_DEPTH 4

`endif
